/* design/async_fifo.sv */
//////////////////////////////////////////////////////////////////////
// Dual-clock FIFO for crossing between sclk and sys_clk.
// Gray-coded pointers cross through two flops each way.
// data_out shows the head word whenever read_ready is high.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module async_fifo #(
    parameter int WIDTH      = 8,
    parameter int DEPTH_LOG2 = 3
) (
    input  logic             reset,

    // Write side.
    input  logic             write_clk,
    input  logic             write_en,
    input  logic [WIDTH-1:0] data_in,
    output logic             write_ready,  // High while there is space.

    // Read side.
    input  logic             read_clk,
    input  logic             read_en,
    output logic [WIDTH-1:0] data_out,
    output logic             read_ready    // High while data_out is valid.
);
    // One extra pointer bit tells full from empty.
    localparam int PTR_W = DEPTH_LOG2 + 1;

    logic [WIDTH-1:0] mem [2**DEPTH_LOG2];

    logic [PTR_W-1:0] wr_bin;
    logic [PTR_W-1:0] wr_bin_next;
    logic [PTR_W-1:0] wr_gray;
    logic [PTR_W-1:0] rd_bin;
    logic [PTR_W-1:0] rd_bin_next;
    logic [PTR_W-1:0] rd_gray;

    // Read pointer seen from the write side, and the other way round.
    logic [PTR_W-1:0] rd_gray_meta;
    logic [PTR_W-1:0] rd_gray_sync;
    logic [PTR_W-1:0] wr_gray_meta;
    logic [PTR_W-1:0] wr_gray_sync;

    logic do_write;
    logic do_read;

    assign wr_bin_next = wr_bin + PTR_W'(1);
    assign rd_bin_next = rd_bin + PTR_W'(1);

    // Full when the pointers differ only in the two top Gray bits.
    assign write_ready = (wr_gray != {~rd_gray_sync[PTR_W-1:PTR_W-2],
                                      rd_gray_sync[PTR_W-3:0]});
    assign read_ready  = (rd_gray != wr_gray_sync);

    assign do_write = write_en && write_ready;
    assign do_read  = read_en && read_ready;

    assign data_out = mem[rd_bin[DEPTH_LOG2-1:0]];

    //////////////////////////////////////////////////////////////////////
    // Write domain.
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge write_clk) begin
        if (reset) begin
            wr_bin       <= '0;
            wr_gray      <= '0;
            rd_gray_meta <= '0;
            rd_gray_sync <= '0;
        end else begin
            rd_gray_meta <= rd_gray;
            rd_gray_sync <= rd_gray_meta;
            if (do_write) begin
                wr_bin  <= wr_bin_next;
                wr_gray <= (wr_bin_next >> 1) ^ wr_bin_next;
            end
        end
    end

    // Storage.
    always_ff @(posedge write_clk) begin
        if (do_write) begin
            mem[wr_bin[DEPTH_LOG2-1:0]] <= data_in;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read domain.
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge read_clk) begin
        if (reset) begin
            rd_bin       <= '0;
            rd_gray      <= '0;
            wr_gray_meta <= '0;
            wr_gray_sync <= '0;
        end else begin
            wr_gray_meta <= wr_gray;
            wr_gray_sync <= wr_gray_meta;
            if (do_read) begin
                rd_bin  <= rd_bin_next;
                rd_gray <= (rd_bin_next >> 1) ^ rd_bin_next;
            end
        end
    end

    // A push into a full FIFO would lose the word.
    assert property (@(posedge write_clk) disable iff (reset) write_en |-> write_ready)
        else $error("async_fifo: write while full");

endmodule

/* design/reg_arbiter.sv */
//////////////////////////////////////////////////////////////////////
// Round-robin arbiter in front of the register bank.
// Grants the SPI engine or the host, one per cycle, and remembers
// who issued the last access so read data can be routed back.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module reg_arbiter (
    input  logic                  sys_clk,
    input  logic                  reset,

    input  logic                  spi_req,
    input  spi_reg_pkg::reg_req_t spi_req_data,
    output logic                  spi_gnt,

    input  logic                  host_req,
    input  spi_reg_pkg::reg_req_t host_req_data,
    output logic                  host_gnt,

    output logic                  bank_en,
    output spi_reg_pkg::reg_req_t bank_req,
    output logic                  rd_owner   // 1 when the host owns the read.
);
    // High when the host wins a tie.
    logic host_first;

    assign spi_gnt  = spi_req && (!host_req || !host_first);
    assign host_gnt = host_req && (!spi_req || host_first);

    assign bank_en  = spi_gnt || host_gnt;
    assign bank_req = host_gnt ? host_req_data : spi_req_data;

    // Priority flips on every grant.
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            host_first <= 1'b0;
            rd_owner   <= 1'b0;
        end else if (bank_en) begin
            host_first <= ~host_first;
            rd_owner   <= host_gnt;
        end
    end

    assert property (@(posedge sys_clk) disable iff (reset) !(spi_gnt && host_gnt))
        else $error("reg_arbiter: two grants in one cycle");

endmodule

/* design/reg_bank.sv */
//////////////////////////////////////////////////////////////////////
// Register array, one access per cycle.
// Writes land at the end of the grant cycle, reads return a cycle
// later with an rvalid pulse.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module reg_bank #(
    parameter int WORD_SIZE = spi_reg_pkg::word_width,
    parameter int NUM_REGS  = 16
) (
    input  logic                  sys_clk,
    input  logic                  reset,
    input  logic                  bank_en,
    input  spi_reg_pkg::reg_req_t bank_req,
    output logic [WORD_SIZE-1:0]  rdata,
    output logic                  rvalid
);
    import spi_reg_pkg::*;

    logic [WORD_SIZE-1:0] regs [NUM_REGS];

    // Register contents and the read strobe.
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            rvalid <= 1'b0;
        end else begin
            rvalid <= bank_en && (bank_req.op == op_read);
            if (bank_en && bank_req.op == op_write) begin
                regs[bank_req.addr] <= bank_req.wdata;
            end
        end
    end

    // Registered read port.
    always_ff @(posedge sys_clk) begin
        if (bank_en && bank_req.op == op_read) begin
            rdata <= regs[bank_req.addr];
        end
    end

endmodule

/* design/spi_cmd_engine.sv */
//////////////////////////////////////////////////////////////////////
// Turns received SPI bytes into register requests.
// Write frame is command then data, read frame is command then two
// dummies. Read data is queued for the third byte of the frame.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module spi_cmd_engine #(
    parameter int WORD_SIZE = spi_reg_pkg::word_width
) (
    input  logic                  sys_clk,
    input  logic                  reset,
    input  logic                  active,

    // Byte stream from the SPI subordinate.
    input  logic [WORD_SIZE-1:0]  rx_data,
    input  logic                  rx_ready,
    output logic                  rx_data_en,
    output logic [WORD_SIZE-1:0]  tx_data,
    output logic                  tx_data_en,
    input  logic                  tx_ready,

    // Requester port toward the arbiter.
    output logic                  req,
    output spi_reg_pkg::reg_req_t req_data,
    input  logic                  gnt,
    input  logic                  rvalid,
    input  logic [WORD_SIZE-1:0]  rdata
);
    import spi_reg_pkg::*;

    cmd_state_e state;
    reg_req_t   cmd_q;
    reg_op_e    rx_op;
    logic       active_meta;
    logic       active_sync;
    logic       rx_take;

    // Opcode of the byte at the FIFO head, if it is a command.
    assign rx_op = reg_op_e'(rx_data[WORD_SIZE-1]);

    // Bytes are consumed only in states that expect one.
    assign rx_take    = rx_ready && (state == st_idle || state == st_wdata ||
                                     state == st_skip);
    assign rx_data_en = rx_take;

    assign req      = (state == st_issue);
    assign req_data = cmd_q;

    // Read data goes straight into the transmit FIFO.
    assign tx_data_en = (state == st_wait_rd) && rvalid;
    assign tx_data    = rdata;

    // ssn is asynchronous to sys_clk.
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            active_meta <= 1'b0;
            active_sync <= 1'b0;
        end else begin
            active_meta <= active;
            active_sync <= active_meta;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Command FSM.
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (rx_ready) begin
                        state <= (rx_op == op_write) ? st_wdata : st_issue;
                    end
                end
                // Frame ended without data, drop the command.
                st_wdata: begin
                    if (rx_ready) begin
                        state <= st_issue;
                    end else if (!active_sync) begin
                        state <= st_idle;
                    end
                end
                st_issue: begin
                    if (gnt) begin
                        state <= (cmd_q.op == op_write) ? st_idle : st_wait_rd;
                    end
                end
                st_wait_rd: begin
                    if (rvalid) begin
                        state <= st_skip;
                    end
                end
                // Dummies are dropped until the frame is over.
                st_skip: begin
                    if (!rx_ready && !active_sync) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Captured command fields.
    always_ff @(posedge sys_clk) begin
        if (state == st_idle && rx_ready) begin
            cmd_q.op   <= rx_op;
            cmd_q.addr <= rx_data[addr_width-1:0];
        end
        if (state == st_wdata && rx_ready) begin
            cmd_q.wdata <= rx_data;
        end
    end

    // rvalid cannot be stalled, so the transmit FIFO must have room.
    assert property (@(posedge sys_clk) disable iff (reset) tx_data_en |-> tx_ready)
        else $error("spi_cmd_engine: read data pushed into a full FIFO");

endmodule

/* design/spi_reg_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared types for the SPI register bank.
// Word and address widths, the access opcode, the command FSM states
// and the request word that every requester hands to the arbiter.
//////////////////////////////////////////////////////////////////////

package spi_reg_pkg;

    // SPI word and register width.
    localparam int word_width = 8;

    // Register address width, 16 registers.
    localparam int addr_width = 4;

    // Access opcode, taken straight from bit 7 of the command byte.
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } reg_op_e;

    // Command engine states.
    typedef enum logic [2:0] {
        st_idle,     // Waiting for a command byte.
        st_wdata,    // Write command seen, waiting for the data byte.
        st_issue,    // Request held toward the arbiter.
        st_wait_rd,  // Read granted, waiting for the bank data.
        st_skip      // Dropping the dummy bytes of a read frame.
    } cmd_state_e;

    // One register access as seen by the arbiter and the bank.
    typedef struct packed {
        reg_op_e                 op;
        logic [addr_width-1:0]   addr;
        logic [word_width-1:0]   wdata;
    } reg_req_t;

endpackage

/* design/spi_reg_top.sv */
//////////////////////////////////////////////////////////////////////
// SPI-addressed register bank, top level.
// SPI frames and the local host port share 16 registers through a
// round-robin arbiter.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module spi_reg_top #(
    parameter int WORD_SIZE  = spi_reg_pkg::word_width,
    parameter int FIFO_DEPTH = 3,
    parameter int NUM_REGS   = 16
) (
    input  logic                  sys_clk,
    input  logic                  reset,

    // SPI pins.
    input  logic                  sclk,
    input  logic                  ssn,
    input  logic                  mosi,
    output logic                  miso,

    // Host port.
    input  logic                  host_req,
    input  spi_reg_pkg::reg_req_t host_req_data,
    output logic                  host_gnt,
    output logic [WORD_SIZE-1:0]  host_rdata,
    output logic                  host_rvalid
);
    import spi_reg_pkg::*;

    // SPI subordinate to command engine.
    logic [WORD_SIZE-1:0] rx_data;
    logic [WORD_SIZE-1:0] tx_data;
    logic                 rx_ready;
    logic                 rx_data_en;
    logic                 tx_ready;
    logic                 tx_data_en;
    logic                 active;

    // Requests and the bank.
    logic                 spi_req;
    reg_req_t             spi_req_data;
    logic                 spi_gnt;
    logic                 spi_rvalid;
    logic                 bank_en;
    reg_req_t             bank_req;
    logic                 rd_owner;
    logic [WORD_SIZE-1:0] bank_rdata;
    logic                 bank_rvalid;

    // Read data goes to whoever was granted the read.
    assign host_rvalid = bank_rvalid && rd_owner;
    assign spi_rvalid  = bank_rvalid && !rd_owner;
    assign host_rdata  = bank_rdata;

    spi_sub #(
        .WORD_SIZE(WORD_SIZE),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) spi_sub_i (
        .sclk(sclk),
        .ssn(ssn),
        .mosi(mosi),
        .miso(miso),
        .sys_clk(sys_clk),
        .reset(reset),
        .tx_data_en(tx_data_en),
        .rx_data_en(rx_data_en),
        .tx_data(tx_data),
        .rx_data(rx_data),
        .tx_ready(tx_ready),
        .rx_ready(rx_ready),
        .active(active)
    );

    spi_cmd_engine #(
        .WORD_SIZE(WORD_SIZE)
    ) cmd_engine_i (
        .sys_clk(sys_clk),
        .reset(reset),
        .active(active),
        .rx_data(rx_data),
        .rx_ready(rx_ready),
        .rx_data_en(rx_data_en),
        .tx_data(tx_data),
        .tx_data_en(tx_data_en),
        .tx_ready(tx_ready),
        .req(spi_req),
        .req_data(spi_req_data),
        .gnt(spi_gnt),
        .rvalid(spi_rvalid),
        .rdata(bank_rdata)
    );

    reg_arbiter arbiter_i (
        .sys_clk(sys_clk),
        .reset(reset),
        .spi_req(spi_req),
        .spi_req_data(spi_req_data),
        .spi_gnt(spi_gnt),
        .host_req(host_req),
        .host_req_data(host_req_data),
        .host_gnt(host_gnt),
        .bank_en(bank_en),
        .bank_req(bank_req),
        .rd_owner(rd_owner)
    );

    reg_bank #(
        .WORD_SIZE(WORD_SIZE),
        .NUM_REGS(NUM_REGS)
    ) reg_bank_i (
        .sys_clk(sys_clk),
        .reset(reset),
        .bank_en(bank_en),
        .bank_req(bank_req),
        .rdata(bank_rdata),
        .rvalid(bank_rvalid)
    );

endmodule

/* design/spi_sub.sv */
//////////////////////////////////////////////////////////////////////
// SPI subordinate, mode 0, MSB first.
// Received words go to sys_clk through one FIFO, words to send come
// back through another. Holds 0x00 on miso when nothing is queued.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module spi_sub #(
    parameter int WORD_SIZE  = spi_reg_pkg::word_width,
    parameter int FIFO_DEPTH = 3
) (
    // SPI pins.
    input  logic                 sclk,
    input  logic                 ssn,
    input  logic                 mosi,
    output logic                 miso,

    // System side.
    input  logic                 sys_clk,
    input  logic                 reset,
    input  logic                 tx_data_en,  // Push tx_data.
    input  logic                 rx_data_en,  // Pop rx_data.
    input  logic [WORD_SIZE-1:0] tx_data,
    output logic [WORD_SIZE-1:0] rx_data,
    output logic                 tx_ready,    // Transmit FIFO has space.
    output logic                 rx_ready,    // rx_data holds a word.
    output logic                 active       // Selected by the main.
);
    localparam int CNT_W = $clog2(WORD_SIZE);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(WORD_SIZE - 1);

    logic [CNT_W-1:0]     bit_cnt;
    logic [WORD_SIZE-1:0] rx_shift;
    logic [WORD_SIZE-1:0] rx_word;
    logic                 rx_word_done;
    logic [WORD_SIZE-1:0] tx_shift;
    logic [WORD_SIZE-1:0] tx_head;
    logic                 tx_head_valid;
    logic                 tx_load;
    logic                 sclk_n;

    assign active = ~ssn;
    assign sclk_n = ~sclk;

    // Bit position in the current word.
    // sclk is idle while deselected, so ssn clears the count directly.
    always_ff @(posedge sclk or posedge ssn) begin
        if (ssn) begin
            bit_cnt <= '0;
        end else if (bit_cnt == LAST_BIT) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Receive path.
    //////////////////////////////////////////////////////////////////////

    // Word including the bit sampled on this edge.
    assign rx_word      = {rx_shift[WORD_SIZE-2:0], mosi};
    assign rx_word_done = (bit_cnt == LAST_BIT);

    always_ff @(posedge sclk) begin
        rx_shift <= rx_word;
    end

    async_fifo #(
        .WIDTH(WORD_SIZE),
        .DEPTH_LOG2(FIFO_DEPTH)
    ) rx_fifo_i (
        .reset(reset),
        .write_clk(sclk),
        .write_en(rx_word_done),
        .data_in(rx_word),
        .write_ready(),
        .read_clk(sys_clk),
        .read_en(rx_data_en),
        .data_out(rx_data),
        .read_ready(rx_ready)
    );

    //////////////////////////////////////////////////////////////////////
    // Transmit path.
    //////////////////////////////////////////////////////////////////////

    // Falling edge after the last bit of a word.
    assign tx_load = (bit_cnt == '0);

    // Cleared on deselect so the first MSB is 0 as soon as ssn falls.
    always_ff @(negedge sclk or posedge ssn) begin
        if (ssn) begin
            tx_shift <= '0;
        end else if (tx_load) begin
            tx_shift <= tx_head_valid ? tx_head : '0;
        end else begin
            tx_shift <= {tx_shift[WORD_SIZE-2:0], 1'b0};
        end
    end

    assign miso = tx_shift[WORD_SIZE-1];

    // Read side runs on falling sclk, together with the shift register.
    async_fifo #(
        .WIDTH(WORD_SIZE),
        .DEPTH_LOG2(FIFO_DEPTH)
    ) tx_fifo_i (
        .reset(reset),
        .write_clk(sys_clk),
        .write_en(tx_data_en),
        .data_in(tx_data),
        .write_ready(tx_ready),
        .read_clk(sclk_n),
        .read_en(tx_load),
        .data_out(tx_head),
        .read_ready(tx_head_valid)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the register bank testbench with Verilator and runs it.
# The run fails when the simulation log holds the fail message.
verilator --binary --timing --assert -f src.f --top-module tb_spi_reg_top -o sim_tb \
    > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "Simulation failed"; exit 1; } || { echo "Simulation passed"; exit 0; }

/* src.f */
design/spi_reg_pkg.sv
design/async_fifo.sv
design/spi_sub.sv
design/spi_cmd_engine.sv
design/reg_arbiter.sv
design/reg_bank.sv
design/spi_reg_top.sv
tests/tb_spi_reg_top.sv

/* tests/tb_spi_reg_top.sv */
//////////////////////////////////////////////////////////////////////
// Directed testbench for the SPI register bank.
// An SPI main model and a host model access the DUT, and every read
// is compared with a 16-entry reference array.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_spi_reg_top;
    import spi_reg_pkg::*;

    // Cycles before any wait gives up.
    localparam int timeout_cycles = 2000;

    logic                  sys_clk;
    logic                  reset;
    logic                  sclk;
    logic                  ssn;
    logic                  mosi;
    logic                  miso;
    logic                  host_req;
    reg_req_t              host_req_data;
    logic                  host_gnt;
    logic [word_width-1:0] host_rdata;
    logic                  host_rvalid;

    // Expected register contents.
    logic [word_width-1:0] ref_regs [16];

    int          checks;
    int          errors;

    spi_reg_top #(
        .WORD_SIZE(word_width),
        .FIFO_DEPTH(3),
        .NUM_REGS(16)
    ) dut_i (
        .sys_clk(sys_clk),
        .reset(reset),
        .sclk(sclk),
        .ssn(ssn),
        .mosi(mosi),
        .miso(miso),
        .host_req(host_req),
        .host_req_data(host_req_data),
        .host_gnt(host_gnt),
        .host_rdata(host_rdata),
        .host_rvalid(host_rvalid)
    );

    // 100 ns system clock.
    initial begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Checks and timing helpers.
    //////////////////////////////////////////////////////////////////////

    task automatic check_byte(input string name, input logic [word_width-1:0] got,
                              input logic [word_width-1:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH %s: got 0x%02h, expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_flag(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("Check failed: %s", what);
        end
    endtask

    // Ends the run when a wait never completes.
    task automatic abort_run(input string what);
        errors++;
        $display("Timeout while waiting for %s", what);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("TEST FAILED");
        $finish;
    endtask

    // Inputs change 1 ns after a rising edge.
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge sys_clk);
        #1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // SPI main model in mode 0 with sclk at ten system clocks.
    //////////////////////////////////////////////////////////////////////

    task automatic spi_xfer_byte(input logic [word_width-1:0] tx,
                                 output logic [word_width-1:0] rx);
        for (int i = word_width - 1; i >= 0; i--) begin
            // mosi changes after the falling edge and the DUT samples it on the rise.
            mosi = tx[i];
            wait_cycles(5);
            rx[i] = miso;
            sclk = 1'b1;
            wait_cycles(5);
            sclk = 1'b0;
        end
    endtask

    task automatic select_sub();
        ssn = 1'b0;
        wait_cycles(2);
    endtask

    // Raises ssn and waits until the command engine has drained the frame.
    task automatic deselect_sub();
        int cnt;
        ssn  = 1'b1;
        mosi = 1'b0;
        cnt  = 0;
        @(negedge sys_clk);
        while (dut_i.cmd_engine_i.active_sync || dut_i.rx_ready ||
               dut_i.cmd_engine_i.state != st_idle) begin
            if (cnt == timeout_cycles) abort_run("the SPI command engine to go idle");
            @(negedge sys_clk);
            cnt++;
        end
    endtask

    task automatic spi_write(input logic [3:0] addr, input logic [word_width-1:0] data);
        logic [word_width-1:0] unused;
        select_sub();
        // Bits 6 to 4 of the command byte carry no meaning.
        spi_xfer_byte({1'b1, 3'($urandom), addr}, unused);
        spi_xfer_byte(data, unused);
        deselect_sub();
    endtask

    task automatic spi_read(input logic [3:0] addr, output logic [word_width-1:0] data);
        logic [word_width-1:0] first;
        logic [word_width-1:0] second;
        select_sub();
        spi_xfer_byte({1'b0, 3'($urandom), addr}, first);
        spi_xfer_byte(8'($urandom), second);
        spi_xfer_byte(8'($urandom), data);
        deselect_sub();
        check_byte("miso byte 1", first, 8'h00);
        check_byte("miso byte 2", second, 8'h00);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Host model.
    //////////////////////////////////////////////////////////////////////

    task automatic host_access(input reg_op_e op, input logic [3:0] addr,
                               input logic [word_width-1:0] wdata,
                               output logic [word_width-1:0] rdata);
        int cnt;
        @(posedge sys_clk);
        #1;
        host_req            = 1'b1;
        host_req_data.op    = op;
        host_req_data.addr  = addr;
        host_req_data.wdata = wdata;
        rdata = '0;
        cnt   = 0;
        @(negedge sys_clk);
        while (!host_gnt) begin
            if (cnt == timeout_cycles) abort_run("host_gnt");
            @(negedge sys_clk);
            cnt++;
        end
        // Grant is taken on the next rising edge.
        @(posedge sys_clk);
        #1;
        host_req = 1'b0;
        if (op == op_read) begin
            cnt = 0;
            @(negedge sys_clk);
            while (!host_rvalid) begin
                if (cnt == timeout_cycles) abort_run("host_rvalid");
                @(negedge sys_clk);
                cnt++;
            end
            check_flag(cnt == 0, "host_rvalid did not come one cycle after host_gnt");
            rdata = host_rdata;
        end
    endtask

    task automatic host_read_all(input string name);
        logic [word_width-1:0] got;
        for (int a = 0; a < 16; a++) begin
            host_access(op_read, 4'(a), 8'h00, got);
            check_byte(name, got, ref_regs[a]);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests.
    //////////////////////////////////////////////////////////////////////

    task automatic check_reset_state();
        @(negedge sys_clk);
        check_flag(host_gnt == 1'b0, "host_gnt is high after reset");
        check_flag(host_rvalid == 1'b0, "host_rvalid is high after reset");
        host_read_all("host_rdata after reset");
    endtask

    task automatic host_write_readback();
        logic [3:0]            addr;
        logic [word_width-1:0] val;
        logic [word_width-1:0] unused;
        for (int n = 0; n < 12; n++) begin
            addr = 4'($urandom_range(15));
            val  = 8'($urandom);
            host_access(op_write, addr, val, unused);
            ref_regs[addr] = val;
        end
        host_read_all("host_rdata after host writes");
    endtask

    task automatic spi_write_host_readback();
        logic [word_width-1:0] val;
        for (int a = 0; a < 16; a++) begin
            val = 8'($urandom);
            spi_write(4'(a), val);
            ref_regs[a] = val;
        end
        host_read_all("host_rdata after SPI writes");
    endtask

    task automatic host_write_spi_readback();
        logic [word_width-1:0] val;
        logic [word_width-1:0] got;
        logic [word_width-1:0] unused;
        for (int a = 0; a < 16; a++) begin
            val = 8'($urandom);
            host_access(op_write, 4'(a), val, unused);
            ref_regs[a] = val;
            spi_read(4'(a), got);
            check_byte("miso byte 3", got, ref_regs[a]);
        end
    endtask

    // Host request lands in the cycle the SPI write is issued.
    task automatic contention_with_host();
        logic [3:0]            spi_addr;
        logic [3:0]            host_addr;
        logic [word_width-1:0] spi_val;
        logic [word_width-1:0] host_val;
        logic [word_width-1:0] got;
        int                    cnt;
        spi_addr  = 4'd6;
        host_addr = 4'd11;
        spi_val   = 8'($urandom);
        host_val  = 8'($urandom);
        cnt       = 0;
        fork
            begin
                spi_write(spi_addr, spi_val);
                ref_regs[spi_addr] = spi_val;
            end
            begin
                @(negedge sys_clk);
                while (!(dut_i.cmd_engine_i.state == st_wdata && dut_i.rx_ready)) begin
                    if (cnt == timeout_cycles) abort_run("the SPI data byte");
                    @(negedge sys_clk);
                    cnt++;
                end
                host_access(op_write, host_addr, host_val, got);
                ref_regs[host_addr] = host_val;
            end
        join
        host_access(op_read, spi_addr, 8'h00, got);
        check_byte("host_rdata after contention", got, ref_regs[spi_addr]);
        spi_read(host_addr, got);
        check_byte("miso byte 3 after contention", got, ref_regs[host_addr]);
    endtask

    task automatic aborted_write_frame();
        logic [3:0]            addr;
        logic [word_width-1:0] got;
        addr = 4'd3;
        select_sub();
        spi_xfer_byte({1'b1, 3'b000, addr}, got);
        // ssn rises before any data byte.
        deselect_sub();
        spi_read(addr, got);
        check_byte("miso byte 3 after aborted write", got, ref_regs[addr]);
        host_access(op_read, addr, 8'h00, got);
        check_byte("host_rdata after aborted write", got, ref_regs[addr]);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence.
    //////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(63));
        checks        = 0;
        errors        = 0;
        reset         = 1'b1;
        sclk          = 1'b0;
        ssn           = 1'b1;
        mosi          = 1'b0;
        host_req      = 1'b0;
        host_req_data = '0;
        for (int a = 0; a < 16; a++) begin
            ref_regs[a] = '0;
        end

        // One sclk rise and fall inside the two reset cycles.
        // Both sclk-side FIFO domains see reset this way.
        #1;
        sclk = 1'b1;
        wait_cycles(1);
        sclk = 1'b0;
        wait_cycles(1);
        reset = 1'b0;

        check_reset_state();
        host_write_readback();
        spi_write_host_readback();
        host_write_spi_readback();
        contention_with_host();
        aborted_write_frame();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
